/* include/taint_consts.svh */
`ifndef TAINT_CONSTS_SVH
`define TAINT_CONSTS_SVH

// operand and taint mask width
`define TAINT_DATA_W 16

// taint store geometry
`define TAINT_SLOTS 8
`define TAINT_SLOT_W 3

// AXI4-Lite bus widths
`define AXI_ADDR_W 8
`define AXI_DATA_W 32

// register map, byte addresses
`define REG_A_VAL 8'h00
`define REG_A_TAINT 8'h04
`define REG_B_VAL 8'h08
`define REG_B_TAINT 8'h0C
`define REG_CMD 8'h10
`define REG_LIVE 8'h14
`define REG_RESULT 8'h18
`define REG_COUNT 8'h1C
`define REG_SLOT_BASE 8'h20

// command register fields
`define CMD_OP_LSB 0
`define CMD_DST_LSB 4

`endif

/* logic/taint_alu.sv */
`include "taint_consts.svh"

module taint_alu (
    input  taint_pkg::taint_word_t a_val,
    input  taint_pkg::taint_word_t a_taint,
    input  taint_pkg::taint_word_t b_val,
    input  taint_pkg::taint_word_t b_taint,
    input  taint_pkg::taint_op_e   op,
    output taint_pkg::taint_word_t result_taint
);

    taint_pkg::taint_word_t and_taint;
    taint_pkg::taint_word_t or_taint;
    taint_pkg::taint_word_t a_lo;
    taint_pkg::taint_word_t a_hi;
    taint_pkg::taint_word_t b_lo;
    taint_pkg::taint_word_t b_hi;
    taint_pkg::taint_word_t sum_lo;
    taint_pkg::taint_word_t sum_hi;
    taint_pkg::taint_word_t diff_lo;
    taint_pkg::taint_word_t diff_hi;
    taint_pkg::taint_word_t either_taint;
    logic                   b_tainted;
    logic                   eq_taint;
    logic                   reduce_or_taint;

    // a tainted input only matters where the other side does not force the result
    assign and_taint = (a_taint & b_val) | (b_taint & a_val) | (a_taint & b_taint);
    assign or_taint  = (a_taint & ~b_val) | (b_taint & ~a_val) | (a_taint & b_taint);

    // extremes of each operand over its tainted bits
    assign a_lo = a_val & ~a_taint;
    assign a_hi = a_val | a_taint;
    assign b_lo = b_val & ~b_taint;
    assign b_hi = b_val | b_taint;

    // carry and borrow chains differ wherever taint can reach, wraps at 16 bits
    assign sum_lo  = a_lo + b_lo;
    assign sum_hi  = a_hi + b_hi;
    assign diff_lo = a_lo - b_lo;
    assign diff_hi = a_hi - b_hi;

    assign either_taint = a_taint | b_taint;
    assign b_tainted    = |b_taint;

    // compare only bits that are clean on both sides
    assign eq_taint = (|either_taint) &&
                      ((a_val & ~either_taint) == (b_val & ~either_taint));

    // a clean 1 already decides the reduction
    assign reduce_or_taint = (|a_taint) && !(|(a_val & ~a_taint));

    always_comb begin
        result_taint = '0;
        case (op)
            taint_pkg::op_and: result_taint = and_taint;
            taint_pkg::op_or:  result_taint = or_taint;
            taint_pkg::op_add: result_taint = (sum_lo ^ sum_hi) | either_taint;
            taint_pkg::op_sub: result_taint = (diff_lo ^ diff_hi) | either_taint;
            taint_pkg::op_shl: begin
                // a tainted shift amount can move any bit anywhere
                result_taint = b_tainted ? '1 : a_taint << b_val;
            end
            taint_pkg::op_shr: begin
                result_taint = b_tainted ? '1 : a_taint >> b_val;
            end
            taint_pkg::op_eq:        result_taint[0] = eq_taint;
            taint_pkg::op_reduce_or: result_taint[0] = reduce_or_taint;
            default: result_taint = '0;
        endcase
    end

endmodule

/* logic/taint_axi_slave.sv */
`include "taint_consts.svh"

module taint_axi_slave (
    input  logic                         pos_clk,
    input  logic                         pos_arst,
    // write address and data
    input  logic [`AXI_ADDR_W-1:0]       awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`AXI_DATA_W-1:0]       wdata,
    input  logic [`AXI_DATA_W/8-1:0]     wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    // write response
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    // read address and data
    input  logic [`AXI_ADDR_W-1:0]       araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`AXI_DATA_W-1:0]       rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    // operands towards the ALU
    output taint_pkg::taint_word_t       a_val,
    output taint_pkg::taint_word_t       a_taint,
    output taint_pkg::taint_word_t       b_val,
    output taint_pkg::taint_word_t       b_taint,
    output taint_pkg::taint_op_e         op,
    // store control
    output logic [`TAINT_SLOTS-1:0]      liveness,
    output logic                         cmd_valid,
    output taint_pkg::slot_idx_t         dst,
    output taint_pkg::slot_idx_t         rd_slot,
    // store results for the read mux
    input  taint_pkg::taint_word_t       slot_taint,
    input  taint_pkg::taint_word_t       last_result,
    input  taint_pkg::taint_count_t      live_count
);

    localparam int OP_W = $bits(taint_pkg::taint_op_e);

    logic                    wr_accept;
    logic                    rd_accept;
    logic                    cmd_wr;
    logic                    slot_hit;
    logic [`AXI_ADDR_W-1:0]  slot_off;
    logic [`AXI_DATA_W-1:0]  rd_word;
    taint_pkg::taint_op_e    wdata_op;
    taint_pkg::slot_idx_t    wdata_dst;
    taint_pkg::taint_op_e    op_q;
    taint_pkg::slot_idx_t    dst_q;

    // address and data are taken together, one outstanding response
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // command fields straight from the bus during the command write
    assign wdata_op  = taint_pkg::taint_op_e'(wdata[`CMD_OP_LSB +: OP_W]);
    assign wdata_dst = wdata[`CMD_DST_LSB +: `TAINT_SLOT_W];
    assign cmd_wr    = wr_accept && (awaddr == `REG_CMD);

    assign cmd_valid = cmd_wr;
    assign op        = cmd_wr ? wdata_op : op_q;
    assign dst       = cmd_wr ? wdata_dst : dst_q;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            bvalid   <= 1'b0;
            a_val    <= '0;
            a_taint  <= '0;
            b_val    <= '0;
            b_taint  <= '0;
            op_q     <= taint_pkg::op_and;
            dst_q    <= '0;
            liveness <= '1;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            case (awaddr)
                `REG_A_VAL:   a_val    <= wdata[`TAINT_DATA_W-1:0];
                `REG_A_TAINT: a_taint  <= wdata[`TAINT_DATA_W-1:0];
                `REG_B_VAL:   b_val    <= wdata[`TAINT_DATA_W-1:0];
                `REG_B_TAINT: b_taint  <= wdata[`TAINT_DATA_W-1:0];
                `REG_LIVE:    liveness <= wdata[`TAINT_SLOTS-1:0];
                `REG_CMD: begin
                    // operands stay as they are, the store takes the result
                    op_q  <= wdata_op;
                    dst_q <= wdata_dst;
                end
                default: ;
            endcase
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // slot window starts at the slot base, one word per slot
    assign slot_off = araddr - `REG_SLOT_BASE;
    assign rd_slot  = slot_off[2 +: `TAINT_SLOT_W];
    assign slot_hit = (araddr >= `REG_SLOT_BASE) &&
                      (int'(araddr) < int'(`REG_SLOT_BASE) + 4 * `TAINT_SLOTS) &&
                      (araddr[1:0] == 2'b00);

    always_comb begin
        rd_word = '0;
        case (araddr)
            `REG_A_VAL:   rd_word[`TAINT_DATA_W-1:0] = a_val;
            `REG_A_TAINT: rd_word[`TAINT_DATA_W-1:0] = a_taint;
            `REG_B_VAL:   rd_word[`TAINT_DATA_W-1:0] = b_val;
            `REG_B_TAINT: rd_word[`TAINT_DATA_W-1:0] = b_taint;
            `REG_LIVE:    rd_word[`TAINT_SLOTS-1:0]  = liveness;
            `REG_RESULT:  rd_word[`TAINT_DATA_W-1:0] = last_result;
            `REG_COUNT:   rd_word[$bits(live_count)-1:0] = live_count;
            `REG_CMD: begin
                rd_word[`CMD_OP_LSB +: OP_W]          = op_q;
                rd_word[`CMD_DST_LSB +: `TAINT_SLOT_W] = dst_q;
            end
            default: begin
                if (slot_hit) begin
                    rd_word[`TAINT_DATA_W-1:0] = slot_taint;
                end
            end
        endcase
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read data held with rvalid until taken
    always_ff @(posedge pos_clk) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

endmodule

/* logic/taint_engine.sv */
`include "taint_consts.svh"

module taint_engine (
    input  logic                      pos_clk,
    input  logic                      pos_arst,
    input  logic [`AXI_ADDR_W-1:0]    awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXI_DATA_W-1:0]    wdata,
    input  logic [`AXI_DATA_W/8-1:0]  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXI_ADDR_W-1:0]    araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXI_DATA_W-1:0]    rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    taint_pkg::taint_word_t   a_val;
    taint_pkg::taint_word_t   a_taint;
    taint_pkg::taint_word_t   b_val;
    taint_pkg::taint_word_t   b_taint;
    taint_pkg::taint_op_e     op;
    logic [`TAINT_SLOTS-1:0]  liveness;
    logic                     cmd_valid;
    taint_pkg::slot_idx_t     dst;
    taint_pkg::slot_idx_t     rd_slot;
    taint_pkg::taint_word_t   result_taint;
    taint_pkg::taint_word_t   slot_taint;
    taint_pkg::taint_word_t   last_result;
    taint_pkg::taint_count_t  live_count;

    taint_axi_slave taint_axi_slave_i (
        .pos_clk     (pos_clk),
        .pos_arst    (pos_arst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .a_val       (a_val),
        .a_taint     (a_taint),
        .b_val       (b_val),
        .b_taint     (b_taint),
        .op          (op),
        .liveness    (liveness),
        .cmd_valid   (cmd_valid),
        .dst         (dst),
        .rd_slot     (rd_slot),
        .slot_taint  (slot_taint),
        .last_result (last_result),
        .live_count  (live_count)
    );

    taint_alu taint_alu_i (
        .a_val        (a_val),
        .a_taint      (a_taint),
        .b_val        (b_val),
        .b_taint      (b_taint),
        .op           (op),
        .result_taint (result_taint)
    );

    taint_store taint_store_i (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .cmd_valid    (cmd_valid),
        .dst          (dst),
        .result_taint (result_taint),
        .liveness     (liveness),
        .rd_slot      (rd_slot),
        .slot_taint   (slot_taint),
        .last_result  (last_result),
        .live_count   (live_count)
    );

endmodule

/* logic/taint_pkg.sv */
`include "taint_consts.svh"

package taint_pkg;

    // propagation rule selected by the command register
    typedef enum logic [2:0] {
        op_and       = 3'd0,
        op_or        = 3'd1,
        op_add       = 3'd2,
        op_sub       = 3'd3,
        op_shl       = 3'd4,
        op_shr       = 3'd5,
        op_eq        = 3'd6,
        op_reduce_or = 3'd7
    } taint_op_e;

    // operand value or taint mask
    typedef logic [`TAINT_DATA_W-1:0] taint_word_t;

    // index into the taint store
    typedef logic [`TAINT_SLOT_W-1:0] slot_idx_t;

    // number of live tainted slots, 0 up to the slot count inclusive
    typedef logic [$clog2(`TAINT_SLOTS+1)-1:0] taint_count_t;

endpackage

/* logic/taint_store.sv */
`include "taint_consts.svh"

module taint_store (
    input  logic                     pos_clk,
    input  logic                     pos_arst,
    input  logic                     cmd_valid,
    input  taint_pkg::slot_idx_t     dst,
    input  taint_pkg::taint_word_t   result_taint,
    input  logic [`TAINT_SLOTS-1:0]  liveness,
    input  taint_pkg::slot_idx_t     rd_slot,
    output taint_pkg::taint_word_t   slot_taint,
    output taint_pkg::taint_word_t   last_result,
    output taint_pkg::taint_count_t  live_count
);

    taint_pkg::taint_word_t slots [`TAINT_SLOTS];

    // enable-gated update, one slot per command
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < `TAINT_SLOTS; i++) begin
                slots[i] <= '0;
            end
            last_result <= '0;
        end else if (cmd_valid) begin
            slots[dst]  <= result_taint;
            last_result <= result_taint;
        end
    end

    assign slot_taint = slots[rd_slot];

    // bitmap liveness, dead slots do not count
    always_comb begin
        live_count = '0;
        for (int i = 0; i < `TAINT_SLOTS; i++) begin
            if ((|slots[i]) && liveness[i]) begin
                live_count = live_count + taint_pkg::taint_count_t'(1);
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the taint engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module taint_engine_tb -f taint_engine.f -o taint_engine_sim

out=$(./obj_dir/taint_engine_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* taint_engine.f */
+incdir+include
logic/taint_pkg.sv
logic/taint_alu.sv
logic/taint_store.sv
logic/taint_axi_slave.sv
logic/taint_engine.sv
testbench/taint_engine_asserts.sv
testbench/taint_engine_checker.sv
testbench/taint_engine_tb.sv

/* testbench/taint_engine_asserts.sv */
`include "taint_consts.svh"

module taint_engine_asserts (
    input logic                    pos_clk,
    input logic                    pos_arst,
    input logic                    awready,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready,
    input logic [`AXI_DATA_W-1:0]  rdata,
    input logic                    cmd_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    write_resp_held: assert property (@(posedge pos_clk) disable iff (pos_arst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    read_resp_held: assert property (@(posedge pos_clk) disable iff (pos_arst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready was seen");

    // an accepted write raises bvalid, which then holds awready low
    no_write_while_resp: assert property (@(posedge pos_clk) disable iff (pos_arst)
        awready |=> bvalid && !awready)
        else $error("bvalid missing or awready high after a write was accepted");

    cmd_single_cycle: assert property (@(posedge pos_clk) disable iff (pos_arst)
        cmd_valid |=> !cmd_valid)
        else $error("cmd_valid lasted more than one cycle");

endmodule

bind taint_axi_slave taint_engine_asserts taint_engine_asserts_i (.*);

/* testbench/taint_engine_checker.sv */
`include "taint_consts.svh"

module taint_engine_checker (
    input  logic                    pos_clk,
    input  logic                    bvalid,
    input  logic                    bready,
    input  logic [1:0]              bresp,
    input  logic                    rvalid,
    input  logic                    rready,
    input  logic [`AXI_DATA_W-1:0]  rdata,
    input  logic [1:0]              rresp,
    input  logic                    exp_push,
    input  logic [`AXI_DATA_W-1:0]  exp_data,
    input  logic [`AXI_ADDR_W-1:0]  exp_addr,
    output int                      error_count,
    output int                      check_count,
    output int                      pending
);
    timeunit 1ns;
    timeprecision 1ps;

    // expected words in read order
    logic [`AXI_DATA_W-1:0] data_q [$];
    logic [`AXI_ADDR_W-1:0] addr_q [$];
    int                     errors = 0;
    int                     checks = 0;
    int                     queued = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign pending     = queued;

    always @(posedge pos_clk) begin
        logic [`AXI_DATA_W-1:0] want;
        logic [`AXI_ADDR_W-1:0] addr;
        // push before pop when both happen at one edge
        if (exp_push) begin
            data_q.push_back(exp_data);
            addr_q.push_back(exp_addr);
        end
        if (bvalid && bready && bresp !== 2'b00) begin
            errors++;
            $display("Fail at %0d ns: bresp expected 0x0, actual 0x%0h", $time, bresp);
        end
        if (rvalid && rready) begin
            if (rresp !== 2'b00) begin
                errors++;
                $display("Fail at %0d ns: rresp expected 0x0, actual 0x%0h", $time, rresp);
            end
            if (data_q.size() == 0) begin
                errors++;
                $display("read response at %0d ns arrived with no read outstanding", $time);
            end else begin
                want = data_q.pop_front();
                addr = addr_q.pop_front();
                checks++;
                if (rdata !== want) begin
                    errors++;
                    $display("Fail at %0d ns: rdata from 0x%02h expected 0x%08h, actual 0x%08h",
                             $time, addr, want, rdata);
                end
            end
        end
        queued = data_q.size();
    end

endmodule

/* testbench/taint_engine_tb.sv */
`include "taint_consts.svh"

module taint_engine_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 25;
    // five writes and two reads per row stay under 40 cycles with the longest stalls
    localparam int TIMEOUT_NS = NUM_ROWS * 40 * CLK_PERIOD + 400 * CLK_PERIOD;

    typedef struct packed {
        taint_pkg::taint_word_t a_val;
        taint_pkg::taint_word_t a_taint;
        taint_pkg::taint_word_t b_val;
        taint_pkg::taint_word_t b_taint;
        taint_pkg::taint_op_e   op;
        taint_pkg::slot_idx_t   dst;
        taint_pkg::taint_word_t expected;
    } case_row_t;

    logic                       pos_clk, pos_arst;
    logic [`AXI_ADDR_W-1:0]     awaddr, araddr;
    logic                       awvalid, awready, wvalid, wready;
    logic [`AXI_DATA_W-1:0]     wdata, rdata;
    logic [`AXI_DATA_W/8-1:0]   wstrb;
    logic [1:0]                 bresp, rresp;
    logic                       bvalid, bready, arvalid, arready, rvalid, rready;
    logic                       exp_push;
    logic [`AXI_DATA_W-1:0]     exp_data;
    logic [`AXI_ADDR_W-1:0]     exp_addr;
    int                         check_errors, reads_checked, reads_pending;
    int                         reads_issued = 0;
    int                         tb_errors = 0;
    integer                     seed = 32'h8d51_fb70;

    // a, at, b, bt, op, dst, expected taint
    case_row_t cases [NUM_ROWS] = '{
        '{16'hF0F0, 16'h0000, 16'hFF00, 16'h0000, taint_pkg::op_and, 3'd0, 16'h0000},
        '{16'h00FF, 16'h0F0F, 16'h3333, 16'h0000, taint_pkg::op_and, 3'd1, 16'h0303},
        '{16'h1234, 16'hFFFF, 16'h5678, 16'hFFFF, taint_pkg::op_and, 3'd2, 16'hFFFF},
        '{16'h00F0, 16'h0F0F, 16'h3333, 16'h0000, taint_pkg::op_or,  3'd3, 16'h0C0C},
        '{16'hFF00, 16'h00F0, 16'h0F0F, 16'hF000, taint_pkg::op_or,  3'd4, 16'h00F0},
        '{16'h0000, 16'hFFFF, 16'h0000, 16'hFFFF, taint_pkg::op_or,  3'd5, 16'hFFFF},
        // carry out of a tainted low bit
        '{16'h0001, 16'h0001, 16'h00FF, 16'h0000, taint_pkg::op_add, 3'd6, 16'h01FF},
        '{16'h1234, 16'h0000, 16'h4321, 16'h0000, taint_pkg::op_add, 3'd7, 16'h0000},
        '{16'h8000, 16'h8000, 16'h0000, 16'h0000, taint_pkg::op_add, 3'd0, 16'h8000},
        // borrow through the low byte
        '{16'h0100, 16'h0000, 16'h0001, 16'h0001, taint_pkg::op_sub, 3'd1, 16'h01FF},
        '{16'h0000, 16'hFFFF, 16'h0000, 16'h0000, taint_pkg::op_sub, 3'd2, 16'hFFFF},
        '{16'h9000, 16'h0000, 16'h1000, 16'h0000, taint_pkg::op_sub, 3'd3, 16'h0000},
        '{16'h0000, 16'h00F1, 16'h0004, 16'h0000, taint_pkg::op_shl, 3'd4, 16'h0F10},
        '{16'h0000, 16'h0001, 16'h0001, 16'h0010, taint_pkg::op_shl, 3'd5, 16'hFFFF},
        '{16'h0000, 16'hF000, 16'h0008, 16'h0000, taint_pkg::op_shr, 3'd6, 16'h00F0},
        '{16'h0000, 16'hFFFF, 16'h0010, 16'h0000, taint_pkg::op_shr, 3'd7, 16'h0000},
        '{16'h0000, 16'h0000, 16'h0000, 16'h8000, taint_pkg::op_shr, 3'd0, 16'hFFFF},
        '{16'h5555, 16'h0000, 16'h5555, 16'h0000, taint_pkg::op_eq,  3'd1, 16'h0000},
        '{16'h1234, 16'h000F, 16'h1230, 16'h0000, taint_pkg::op_eq,  3'd2, 16'h0001},
        '{16'h1234, 16'h000F, 16'h2230, 16'h0000, taint_pkg::op_eq,  3'd3, 16'h0000},
        '{16'h1234, 16'hFFFF, 16'h0000, 16'hFFFF, taint_pkg::op_eq,  3'd4, 16'h0001},
        '{16'h0000, 16'h0F00, 16'h0000, 16'h0000, taint_pkg::op_reduce_or, 3'd5, 16'h0001},
        '{16'h0001, 16'h0F00, 16'h0000, 16'h0000, taint_pkg::op_reduce_or, 3'd6, 16'h0000},
        '{16'hFFFF, 16'h0000, 16'h0000, 16'h0000, taint_pkg::op_reduce_or, 3'd7, 16'h0000},
        '{16'h1234, 16'hFFFF, 16'h0000, 16'h0000, taint_pkg::op_reduce_or, 3'd0, 16'h0001}
    };

    taint_engine taint_engine_i (.*);

    taint_engine_checker checker_i (
        .pos_clk     (pos_clk),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .exp_push    (exp_push),
        .exp_data    (exp_data),
        .exp_addr    (exp_addr),
        .error_count (check_errors),
        .check_count (reads_checked),
        .pending     (reads_pending)
    );

    initial begin
        pos_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
    end

    function automatic logic [`AXI_ADDR_W-1:0] slot_addr(input int idx);
        return `REG_SLOT_BASE + 8'(4 * idx);
    endfunction

    task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data);
        int stall;
        stall = $unsigned($random(seed)) % 4;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge pos_clk);
        while (!(awready && wready)) @(posedge pos_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // hold off the response for a while
        repeat (stall) @(posedge pos_clk);
        bready <= 1'b1;
        @(posedge pos_clk);
        while (!bvalid) @(posedge pos_clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr,
                            input logic [`AXI_DATA_W-1:0] expected);
        int stall;
        stall = $unsigned($random(seed)) % 4;
        exp_push <= 1'b1;
        exp_data <= expected;
        exp_addr <= addr;
        araddr   <= addr;
        arvalid  <= 1'b1;
        @(posedge pos_clk);
        exp_push <= 1'b0;
        while (!arready) @(posedge pos_clk);
        arvalid <= 1'b0;
        repeat (stall) @(posedge pos_clk);
        rready <= 1'b1;
        @(posedge pos_clk);
        while (!rvalid) @(posedge pos_clk);
        rready <= 1'b0;
        reads_issued++;
    endtask

    task automatic run_case(input case_row_t row);
        logic [`AXI_DATA_W-1:0] cmd;
        cmd = (32'(row.dst) << `CMD_DST_LSB) | (32'(row.op) << `CMD_OP_LSB);
        axi_write(`REG_A_VAL, 32'(row.a_val));
        axi_write(`REG_A_TAINT, 32'(row.a_taint));
        axi_write(`REG_B_VAL, 32'(row.b_val));
        axi_write(`REG_B_TAINT, 32'(row.b_taint));
        axi_write(`REG_CMD, cmd);
        axi_read(`REG_RESULT, 32'(row.expected));
        axi_read(slot_addr(int'(row.dst)), 32'(row.expected));
    endtask

    initial begin
        case_row_t clear_row;
        pos_arst = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '1;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        exp_push = 1'b0;
        exp_data = '0;
        exp_addr = '0;
        repeat (2) @(posedge pos_clk);
        pos_arst <= 1'b0;

        // state right after reset
        axi_read(`REG_A_VAL, 32'h0);
        axi_read(`REG_RESULT, 32'h0);
        for (int i = 0; i < `TAINT_SLOTS; i++) begin
            axi_read(slot_addr(i), 32'h0);
        end
        axi_read(`REG_COUNT, 32'h0);
        axi_read(`REG_LIVE, 32'h0000_00FF);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_case(cases[i]);
        end

        // slots 0, 2, 4 and 5 hold taint after the table
        axi_read(`REG_COUNT, 32'd4);
        axi_write(`REG_LIVE, 32'h0000_0031);
        axi_read(`REG_COUNT, 32'd3);
        clear_row     = '0;
        clear_row.op  = taint_pkg::op_or;
        clear_row.dst = 3'd4;
        run_case(clear_row);
        // last command was or into slot 4
        axi_read(`REG_CMD, 32'h0000_0041);
        axi_read(`REG_COUNT, 32'd2);

        repeat (4) @(posedge pos_clk);
        if (reads_pending != 0 || reads_checked != reads_issued || rvalid || bvalid) begin
            tb_errors++;
            $display("%0d reads were issued but %0d responses were checked, rvalid %0b bvalid %0b",
                     reads_issued, reads_checked, rvalid, bvalid);
        end
        $display("reads checked %0d, checker errors %0d, other errors %0d",
                 reads_checked, check_errors, tb_errors);
        if (check_errors + tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the run did not complete", TIMEOUT_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
